/* Bender.yml */
package:
  name: aes128_encrypt

sources:
  - aes_pkg.sv
  - aes_key_schedule.sv
  - aes_round.sv
  - aes_round_ctrl.sv
  - aes128_encrypt.sv
  - target: simulation
    files:
      - tb_aes128_encrypt.sv

/* aes128_encrypt.sv */
`timescale 1ns/1ps

module aes128_encrypt (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  aes_pkg::aes_request_t req,
    output logic                  busy,
    output logic                  done,
    output aes_pkg::block_t       ciphertext
);

    logic            key_load;
    logic            key_step;
    logic            last_round;
    aes_pkg::block_t round_key;
    aes_pkg::block_t state;
    aes_pkg::block_t round_out;

    aes_round_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .req        (req),
        .round_key  (round_key),
        .round_out  (round_out),
        .key_load   (key_load),
        .key_step   (key_step),
        .state      (state),
        .last_round (last_round),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .reset     (reset),
        .key_load  (key_load),
        .key_step  (key_step),
        .key       (req.key),
        .round_key (round_key)
    );

    aes_round u_round (
        .state      (state),
        .round_key  (round_key),
        .last_round (last_round),
        .round_out  (round_out)
    );

endmodule

/* aes_key_schedule.sv */
`timescale 1ns/1ps

module aes_key_schedule (
    input  logic            clk,
    input  logic            reset,
    input  logic            key_load,
    input  logic            key_step,
    input  aes_pkg::block_t key,
    output aes_pkg::block_t round_key
);

    // words per key
    localparam int unsigned nk = aes_pkg::key_w / aes_pkg::word_w;

    logic [7:0]      rcon;
    aes_pkg::block_t key_from_load;
    aes_pkg::block_t key_from_step;

    function automatic aes_pkg::word_t rot_word(input aes_pkg::word_t w);
        return {w[aes_pkg::word_w-9:0], w[aes_pkg::word_w-1 -: 8]};
    endfunction

    // one AES-128 expansion step, four words in, four words out
    function automatic aes_pkg::block_t expand_key(input aes_pkg::block_t k,
                                                   input logic [7:0] rc);
        aes_pkg::word_t  temp;
        aes_pkg::word_t  prev;
        aes_pkg::block_t next;
        prev = aes_pkg::get_word(k, nk - 1);
        temp = aes_pkg::sub_word(rot_word(prev)) ^ {rc, 24'h000000};
        for (int j = 0; j < nk; j++) begin
            // each new word chains off the one before it
            prev = aes_pkg::get_word(k, j) ^ temp;
            next[aes_pkg::block_w-1-aes_pkg::word_w*j -: aes_pkg::word_w] = prev;
            temp = prev;
        end
        return next;
    endfunction

    assign key_from_load = expand_key(key, aes_pkg::rcon_init);
    assign key_from_step = expand_key(round_key, rcon);

    always_ff @(posedge clk) begin
        if (reset) begin
            rcon <= aes_pkg::rcon_init;
        end else if (key_load) begin
            rcon <= aes_pkg::gf_xtime(aes_pkg::rcon_init);
        end else if (key_step) begin
            rcon <= aes_pkg::gf_xtime(rcon);
        end
    end

    always_ff @(posedge clk) begin
        if (key_load) begin
            round_key <= key_from_load;
        end else if (key_step) begin
            round_key <= key_from_step;
        end
    end

    // controller never loads and steps in the same cycle
    assert property (@(posedge clk) disable iff (reset)
        !(key_load && key_step))
        else $error("key schedule: key_load and key_step both high");

endmodule

/* aes_pkg.sv */
package aes_pkg;

    localparam int unsigned block_w     = 128;
    localparam int unsigned key_w       = 128;
    localparam int unsigned word_w      = 32;
    localparam int unsigned num_rounds  = 10;
    localparam int unsigned round_cnt_w = 4;

    // byte 0 in the top bits, columns of four bytes as in FIPS-197
    typedef logic [block_w-1:0] block_t;
    typedef logic [word_w-1:0]  word_t;

    typedef struct packed {
        block_t key;
        block_t plaintext;
    } aes_request_t;

    // first round constant, doubled in GF(2^8) for each later round
    localparam logic [7:0] rcon_init = 8'h01;

    // multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_xtime(input logic [7:0] a);
        logic [7:0] shifted;
        shifted = {a[6:0], 1'b0};
        if (a[7]) begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

    // shift-and-add multiply
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ p;
            end
            p = gf_xtime(p);
        end
        return acc;
    endfunction

    // a^254, which is the inverse for nonzero a and zero for zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] result;
        logic [7:0] sq;
        result = 8'h01;
        sq     = a;
        for (int i = 1; i < 8; i++) begin
            // sq walks through a^2, a^4 ... a^128
            sq     = gf_mul(sq, sq);
            result = gf_mul(result, sq);
        end
        return result;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] a, input int unsigned n);
        logic [15:0] twice;
        twice = {a, a} << n;
        return twice[15:8];
    endfunction

    // forward s-box: field inverse then affine map
    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] inv;
        logic [7:0] affine;
        inv    = gf_inv(a);
        affine = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4);
        return affine ^ 8'h63;
    endfunction

    function automatic word_t sub_word(input word_t w);
        word_t result;
        for (int b = 0; b < 4; b++) begin
            result[8*b +: 8] = sbox(w[8*b +: 8]);
        end
        return result;
    endfunction

    // byte i of a block, byte 0 being the most significant
    function automatic logic [7:0] get_byte(input block_t blk, input int unsigned i);
        return blk[block_w-1-8*i -: 8];
    endfunction

    // word j of a block, word 0 being the most significant
    function automatic word_t get_word(input block_t blk, input int unsigned j);
        return blk[block_w-1-word_w*j -: word_w];
    endfunction

endpackage

/* aes_round.sv */
`timescale 1ns/1ps

module aes_round (
    input  aes_pkg::block_t state,
    input  aes_pkg::block_t round_key,
    input  logic            last_round,
    output aes_pkg::block_t round_out
);

    aes_pkg::block_t shifted;
    aes_pkg::block_t mixed;

    // SubBytes and ShiftRows in one pass
    always_comb begin
        int unsigned src;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                // row r moves left by r columns
                src = r + 4 * ((c + r) % 4);
                shifted[aes_pkg::block_w-1-8*(r+4*c) -: 8] =
                    aes_pkg::sbox(aes_pkg::get_byte(state, src));
            end
        end
    end

    // MixColumns
    always_comb begin
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        for (int c = 0; c < 4; c++) begin
            b0 = aes_pkg::get_byte(shifted, 4*c);
            b1 = aes_pkg::get_byte(shifted, 4*c + 1);
            b2 = aes_pkg::get_byte(shifted, 4*c + 2);
            b3 = aes_pkg::get_byte(shifted, 4*c + 3);
            mixed[aes_pkg::block_w-1-32*c -: 8] =
                aes_pkg::gf_mul(b0, 8'h02) ^ aes_pkg::gf_mul(b1, 8'h03) ^ b2 ^ b3;
            mixed[aes_pkg::block_w-9-32*c -: 8] =
                b0 ^ aes_pkg::gf_mul(b1, 8'h02) ^ aes_pkg::gf_mul(b2, 8'h03) ^ b3;
            mixed[aes_pkg::block_w-17-32*c -: 8] =
                b0 ^ b1 ^ aes_pkg::gf_mul(b2, 8'h02) ^ aes_pkg::gf_mul(b3, 8'h03);
            mixed[aes_pkg::block_w-25-32*c -: 8] =
                aes_pkg::gf_mul(b0, 8'h03) ^ b1 ^ b2 ^ aes_pkg::gf_mul(b3, 8'h02);
        end
    end

    // final round has no MixColumns
    assign round_out = (last_round ? shifted : mixed) ^ round_key;

endmodule

/* aes_round_ctrl.sv */
`timescale 1ns/1ps

module aes_round_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  aes_pkg::aes_request_t req,
    input  aes_pkg::block_t       round_key,
    input  aes_pkg::block_t       round_out,
    output logic                  key_load,
    output logic                  key_step,
    output aes_pkg::block_t       state,
    output logic                  last_round,
    output logic                  busy,
    output logic                  done,
    output aes_pkg::block_t       ciphertext
);

    localparam logic [aes_pkg::round_cnt_w-1:0] last_cnt =
        aes_pkg::num_rounds[aes_pkg::round_cnt_w-1:0];

    logic [aes_pkg::round_cnt_w-1:0] round_cnt;
    logic                            accept;

    // starts while busy are dropped
    assign accept     = start && !busy;
    assign last_round = busy && (round_cnt == last_cnt);

    assign key_load = accept;
    // no key is needed past the final round
    assign key_step = busy && !last_round;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            round_cnt  <= '0;
            ciphertext <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                round_cnt <= 1;
            end else if (busy) begin
                if (last_round) begin
                    busy       <= 1'b0;
                    done       <= 1'b1;
                    round_cnt  <= '0;
                    ciphertext <= round_out;
                end else begin
                    round_cnt <= round_cnt + 1'b1;
                end
            end
        end
    end

    // initial AddRoundKey on load, one round per cycle after that
    always_ff @(posedge clk) begin
        if (accept) begin
            state <= req.plaintext ^ req.key;
        end else if (busy) begin
            state <= round_out;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held for more than one cycle");

    assert property (@(posedge clk) disable iff (reset)
        round_cnt <= last_cnt)
        else $error("round counter past last round");

    // busy for every round, then done right after the last one
    assert property (@(posedge clk) disable iff (reset)
        accept |=> busy [*aes_pkg::num_rounds] ##1 (done && !busy))
        else $error("done not seen %0d cycles after start", aes_pkg::num_rounds);

    // key schedule must be holding a real key while rounds run
    assert property (@(posedge clk) disable iff (reset)
        busy |-> !$isunknown(round_key))
        else $error("round key unknown during a round");

endmodule

/* sim.f */
aes_pkg.sv
aes_key_schedule.sv
aes_round.sv
aes_round_ctrl.sv
aes128_encrypt.sv
tb_aes128_encrypt.sv

/* tb_aes128_encrypt.sv */
`timescale 1ns/1ps

module tb_aes128_encrypt;

    // six tests of up to about 25 cycles, reset and idle gaps, plus margin
    localparam int max_cycles       = 300;
    localparam int done_wait_limit  = 40;
    localparam int expected_latency = 10;

    localparam aes_pkg::block_t c1_key  = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::block_t c1_pt   = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t c1_ct   = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aes_pkg::block_t b_key   = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_pkg::block_t b_pt    = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aes_pkg::block_t b_ct    = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam aes_pkg::block_t zero    = 128'h0;
    localparam aes_pkg::block_t zero_ct = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic                  clk;
    logic                  reset;
    logic                  start;
    aes_pkg::aes_request_t req;
    logic                  busy;
    logic                  done;
    aes_pkg::block_t       ciphertext;

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;

    aes128_encrypt UUT (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .req        (req),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("run stopped after %0d cycles before the tests finished", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // outputs settle at the edge and inputs change 1 ns later
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
        end
    endtask

    task automatic issue_request(input aes_pkg::block_t key, input aes_pkg::block_t plaintext);
        start         = 1'b1;
        req.key       = key;
        req.plaintext = plaintext;
        step();
        start = 1'b0;
    endtask

    // counts cycles after the start cycle until done shows up
    task automatic wait_done(output int cycles, input bit hold_check,
                             input aes_pkg::block_t held);
        cycles = 0;
        while (!done && cycles <= done_wait_limit) begin
            if (hold_check) begin
                check_value("ciphertext", ciphertext, held);
            end
            step();
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("done never came within %0d cycles of the start", done_wait_limit);
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = 1 + ($urandom % 4);
        repeat (gap) step();
    endtask

    task automatic run_vector(input string label, input aes_pkg::block_t key,
                              input aes_pkg::block_t plaintext, input aes_pkg::block_t expected);
        int cycles;
        $display("test: %s", label);
        issue_request(key, plaintext);
        wait_done(cycles, 1'b0, zero);
        check_value("latency", cycles, expected_latency);
        check_value("ciphertext", ciphertext, expected);
    endtask

    task automatic test_timing();
        $display("test: reset state and done timing");
        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);
        check_value("ciphertext", ciphertext, zero);
        issue_request(c1_key, c1_pt);
        for (int i = 1; i <= expected_latency; i++) begin
            check_value("busy", busy, 1'b1);
            check_value("done", done, 1'b0);
            step();
        end
        check_value("done", done, 1'b1);
        check_value("busy", busy, 1'b0);
        check_value("ciphertext", ciphertext, c1_ct);
        step();
        check_value("done", done, 1'b0);
    endtask

    task automatic test_ignored_start();
        int cycles;
        int pulses;
        $display("test: start while busy");
        issue_request(b_key, b_pt);
        repeat (3) step();
        // the core is mid-encryption so this start is dropped
        issue_request(zero, c1_pt);
        wait_done(cycles, 1'b0, zero);
        check_value("latency", cycles + 4, expected_latency);
        check_value("ciphertext", ciphertext, b_ct);
        pulses = 0;
        repeat (15) begin
            step();
            if (done) begin
                pulses++;
            end
        end
        check_value("extra done pulses", pulses, 0);
        check_value("busy", busy, 1'b0);
        check_value("ciphertext", ciphertext, b_ct);
    endtask

    task automatic test_back_to_back();
        int cycles;
        $display("test: back-to-back requests");
        issue_request(zero, zero);
        wait_done(cycles, 1'b0, zero);
        check_value("ciphertext", ciphertext, zero_ct);
        // second start lands in the done cycle
        issue_request(c1_key, c1_pt);
        check_value("busy", busy, 1'b1);
        wait_done(cycles, 1'b1, zero_ct);
        check_value("latency", cycles, expected_latency);
        check_value("ciphertext", ciphertext, c1_ct);
        repeat (5) step();
        check_value("ciphertext", ciphertext, c1_ct);
    endtask

    initial begin
        void'($urandom(40));
        clk   = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        req   = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_timing();
        idle_gap();
        run_vector("FIPS-197 C.1", c1_key, c1_pt, c1_ct);
        idle_gap();
        run_vector("FIPS-197 B", b_key, b_pt, b_ct);
        idle_gap();
        run_vector("all-zero key and block", zero, zero, zero_ct);
        idle_gap();
        test_ignored_start();
        idle_gap();
        test_back_to_back();
        idle_gap();

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
